// File: src/sat_settings.svh
`ifndef SAT_SETTINGS_SVH
`define SAT_SETTINGS_SVH

// literals per clause, each one a candidate flip
`define SAT_NSAT 3

// variable address width
`define SAT_LAW 6

`define SAT_NUM_VARS 64 // 2**SAT_LAW truth bits

// enough bits to index NSAT flips
`define SAT_NSAT_BITS 2

// break count saturates at all ones
`define SAT_BREAK_W 8

`endif

// File: src/sat_pkg.sv
`include "sat_settings.svh"

package sat_pkg;

    typedef struct packed {
        logic                neg;      // literal is the negated variable
        logic [`SAT_LAW-1:0] var_addr; // variable address
    } literal_t;

    // the other NSAT-1 literals of one clause-table occurrence
    typedef struct packed {
        literal_t [`SAT_NSAT-2:0] lits;
    } clause_rest_t;

    typedef struct packed {
        literal_t [`SAT_NSAT-1:0] lits; // lits[0] first
    } clause_t;

    typedef struct packed {
        logic [`SAT_NSAT_BITS-1:0] index; // flip this count belongs to
        logic [`SAT_BREAK_W-1:0]   count; // breaks seen for that flip
        logic                      last;  // flip NSAT-1, job ends here
    } count_msg_t;

    typedef struct packed {
        logic [`SAT_NSAT_BITS-1:0] index; // target row of the rest buffer
        clause_rest_t              rest;  // literals of the broken occurrence
    } buf_write_t;

    typedef struct packed {
        literal_t                flip_lit;      // literal chosen to flip
        logic [`SAT_BREAK_W-1:0] break_count;   // its break count
        logic                    broken_valid;  // broken_clause holds real data
        clause_t                 broken_clause; // last clause broken by the flip
    } flip_result_t;

endpackage

// File: src/assignment_store.sv
`timescale 1ns/1ps
`include "sat_settings.svh"

module assignment_store (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load_we_i,    // host load strobe
    input  logic [`SAT_LAW-1:0]      load_var_i,   // variable to load
    input  logic                     load_val_i,   // value to load
    input  logic                     commit_i,     // flip commit strobe
    input  sat_pkg::literal_t        commit_lit_i, // literal picked by the selector
    output logic [`SAT_NUM_VARS-1:0] values_o      // current assignment
);

    logic [`SAT_NUM_VARS-1:0] values; // one truth bit per variable

    always_ff @(posedge clk) begin
        if (reset) begin
            values <= '0; // all variables start false
        end else if (load_we_i) begin
            values[load_var_i] <= load_val_i;
        end else if (commit_i) begin
            // flipping only depends on the variable, the sign of the literal is irrelevant
            values[commit_lit_i.var_addr] <= ~values[commit_lit_i.var_addr];
        end
    end

    assign values_o = values; // read by the break counter

    // loads belong between jobs, so they can never meet the end-of-job commit
    load_vs_commit: assert property (
        @(posedge clk) disable iff (reset)
        !(load_we_i && commit_i)
    ) else $error("ERROR: assignment load collides with flip commit");

endmodule

// File: src/break_counter.sv
`timescale 1ns/1ps
`include "sat_settings.svh"

module break_counter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start_i,       // job start
    input  logic                     occ_valid_i,   // occurrence strobe
    input  sat_pkg::clause_rest_t    occ_rest_i,    // other literals of the occurrence
    input  logic                     occ_last_i,    // last occurrence of this flip
    input  logic [`SAT_NUM_VARS-1:0] values_i,      // assignment before the flip
    output logic                     buf_we_o,      // rest buffer write strobe
    output sat_pkg::buf_write_t      buf_write_o,   // broken occurrence + flip index
    output logic                     count_valid_o, // count message strobe
    output sat_pkg::count_msg_t      count_o        // finished count of one flip
);

    logic                      busy;      // job in progress
    logic [`SAT_NSAT_BITS-1:0] flip_idx;  // flip whose occurrences are streaming
    logic [`SAT_BREAK_W-1:0]   run_count; // breaks so far for flip_idx
    logic [`SAT_BREAK_W-1:0]   next_count;
    logic                      all_false; // no rest literal is true
    logic                      hit;       // occurrence breaks
    logic                      last_flip;

    // after the flip the complement literal is false, so the clause breaks
    // when none of its other literals can hold it up
    always_comb begin
        all_false = 1'b1;
        for (int k = 0; k < `SAT_NSAT-1; k++) begin
            if (values_i[occ_rest_i.lits[k].var_addr] ^ occ_rest_i.lits[k].neg) begin
                all_false = 1'b0; // literal true
            end
        end
    end

    assign hit        = occ_valid_i && busy && all_false;
    assign next_count = (hit && run_count != '1) ? run_count + 1'b1 : run_count; // saturate
    assign last_flip  = (flip_idx == `SAT_NSAT_BITS'(`SAT_NSAT-1));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy          <= 1'b0;
            flip_idx      <= '0;
            run_count     <= '0;
            buf_we_o      <= 1'b0;
            count_valid_o <= 1'b0;
        end else begin
            buf_we_o      <= hit;                              // keep the latest break
            count_valid_o <= occ_valid_i && busy && occ_last_i;
            if (start_i) begin
                busy      <= 1'b1;
                flip_idx  <= '0; // flips run 0 .. NSAT-1
                run_count <= '0;
            end else if (occ_valid_i && busy) begin
                if (occ_last_i) begin
                    run_count <= '0;             // fresh count for the next flip
                    flip_idx  <= flip_idx + 1'b1;
                    if (last_flip) busy <= 1'b0; // job fully streamed
                end else begin
                    run_count <= next_count;
                end
            end
        end
    end

    // payload registers, qualified by the strobes above
    always_ff @(posedge clk) begin
        buf_write_o.index <= flip_idx;
        buf_write_o.rest  <= occ_rest_i;
        count_o.index     <= flip_idx;
        count_o.count     <= next_count; // includes the closing occurrence
        count_o.last      <= last_flip;
    end

    occ_while_idle: assert property (
        @(posedge clk) disable iff (reset)
        occ_valid_i |-> busy
    ) else $error("ERROR: occurrence received with no job running");

endmodule

// File: src/flip_selector.sv
`timescale 1ns/1ps
`include "sat_settings.svh"

module flip_selector (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_i,       // job start, clears the best
    input  logic                      count_valid_i, // count message strobe
    input  sat_pkg::count_msg_t       count_i,       // finished count of one flip
    output logic                      rd_en_o,       // buffer read strobe
    output logic [`SAT_NSAT_BITS-1:0] rd_index_o,    // winning flip, combinational
    output logic                      done_o,        // job result ready
    output logic [`SAT_NSAT_BITS-1:0] best_index_o,  // chosen flip
    output logic [`SAT_BREAK_W-1:0]   best_count_o   // its break count
);

    logic [`SAT_NSAT_BITS-1:0] best_idx; // best flip so far
    logic [`SAT_BREAK_W-1:0]   best_cnt; // its count
    logic                      take;     // incoming count wins
    logic [`SAT_NSAT_BITS-1:0] cand_idx;
    logic [`SAT_BREAK_W-1:0]   cand_cnt;

    // strictly lower only, so a tie keeps the earlier flip
    assign take     = count_valid_i && (count_i.count < best_cnt);
    assign cand_idx = take ? count_i.index : best_idx;
    assign cand_cnt = take ? count_i.count : best_cnt;

    // last count folds in the same cycle so the read can forward the last write
    assign rd_en_o    = count_valid_i && count_i.last;
    assign rd_index_o = cand_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            best_idx <= '0;
            best_cnt <= '1;
            done_o   <= 1'b0;
        end else begin
            done_o <= rd_en_o; // read data lands together with done
            if (start_i) begin
                best_idx <= '0; // a saturated flip 0 still wins by default
                best_cnt <= '1;
            end else if (count_valid_i) begin
                best_idx <= cand_idx;
                best_cnt <= cand_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_o) begin
            best_index_o <= cand_idx;
            best_count_o <= cand_cnt;
        end
    end

    // the closing count must belong to the last flip
    read_on_last_flip: assert property (
        @(posedge clk) disable iff (reset)
        rd_en_o |-> count_valid_i && count_i.index == `SAT_NSAT_BITS'(`SAT_NSAT-1)
    ) else $error("ERROR: buffer read on a count that is not from the last flip");

endmodule

// File: src/temporal_buffer.sv
`timescale 1ns/1ps
`include "sat_settings.svh"

module temporal_buffer #(
    parameter type payload_t = logic // row contents
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wr_en_i,    // write strobe
    input  logic [`SAT_NSAT_BITS-1:0] wr_index_i, // flip row to write
    input  payload_t                  wr_data_i,
    input  logic                      rd_en_i,    // read strobe
    input  logic [`SAT_NSAT_BITS-1:0] rd_index_i, // flip row to read
    output payload_t                  rd_data_o   // registered read data
);

    localparam int DEPTH = `SAT_NSAT; // one row per flip

    payload_t table_q [DEPTH]; // per-flip rows
    logic     fwd;             // read hits the row being written

    assign fwd = wr_en_i && (wr_index_i == rd_index_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                table_q[i] <= '0;
            end
            rd_data_o <= '0;
        end else begin
            if (wr_en_i) table_q[wr_index_i] <= wr_data_i;
            if (rd_en_i) begin
                // write-through covers a break on the very last occurrence
                rd_data_o <= fwd ? wr_data_i : table_q[rd_index_i];
            end
        end
    end

    index_range: assert property (
        @(posedge clk) disable iff (reset)
        (wr_en_i -> wr_index_i < DEPTH) && (rd_en_i -> rd_index_i < DEPTH)
    ) else $error("ERROR: temporal buffer index out of range");

endmodule

// File: src/temporal_buffer_wrapper.sv
`timescale 1ns/1ps
`include "sat_settings.svh"

module temporal_buffer_wrapper (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start_i,         // job start
    input  sat_pkg::clause_t          clause_i,        // unsatisfied clause, with start
    input  logic                      buf_we_i,        // broken occurrence write
    input  sat_pkg::buf_write_t       buf_write_i,
    input  logic                      rd_en_i,         // read of the winning flip
    input  logic [`SAT_NSAT_BITS-1:0] rd_index_i,
    output sat_pkg::literal_t         flip_lit_o,      // registered flip literal
    output sat_pkg::clause_t          broken_clause_o  // clause broken by that flip
);

    sat_pkg::clause_t          lit_pend;    // clause held while its literals load
    logic [`SAT_NSAT_BITS-1:0] lit_cnt;     // next literal row to load
    logic                      lit_busy;    // loading rows 1 .. NSAT-1
    logic                      lit_we;
    logic [`SAT_NSAT_BITS-1:0] lit_wr_idx;
    sat_pkg::literal_t         lit_wr_data;
    sat_pkg::clause_rest_t     rest_rd;     // stored rest literals

    // row 0 goes in at start, the rest one per cycle after
    assign lit_we      = start_i || lit_busy;
    assign lit_wr_idx  = start_i ? '0 : lit_cnt;
    assign lit_wr_data = start_i ? clause_i.lits[0] : lit_pend.lits[lit_cnt];

    always_ff @(posedge clk) begin
        if (reset) begin
            lit_busy <= 1'b0;
            lit_cnt  <= '0;
        end else if (start_i) begin
            lit_busy <= 1'b1;
            lit_cnt  <= `SAT_NSAT_BITS'(1);
        end else if (lit_busy) begin
            lit_cnt <= lit_cnt + 1'b1;
            if (lit_cnt == `SAT_NSAT_BITS'(`SAT_NSAT-1)) lit_busy <= 1'b0; // all rows loaded
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) lit_pend <= clause_i;
    end

    temporal_buffer #(.payload_t(sat_pkg::clause_rest_t)) u_rest_buf (
        .clk        (clk),
        .reset      (reset),
        .wr_en_i    (buf_we_i),
        .wr_index_i (buf_write_i.index),
        .wr_data_i  (buf_write_i.rest),
        .rd_en_i    (rd_en_i),
        .rd_index_i (rd_index_i),
        .rd_data_o  (rest_rd)
    );

    temporal_buffer #(.payload_t(sat_pkg::literal_t)) u_lit_buf (
        .clk        (clk),
        .reset      (reset),
        .wr_en_i    (lit_we),
        .wr_index_i (lit_wr_idx),
        .wr_data_i  (lit_wr_data),
        .rd_en_i    (rd_en_i),
        .rd_index_i (rd_index_i),
        .rd_data_o  (flip_lit_o)
    );

    // the broken clause held the complement of the flipped literal
    always_comb begin
        broken_clause_o.lits[0] = '{neg: ~flip_lit_o.neg, var_addr: flip_lit_o.var_addr};
        for (int k = 1; k < `SAT_NSAT; k++) begin
            broken_clause_o.lits[k] = rest_rd.lits[k-1];
        end
    end

endmodule

// File: src/flip_eval_top.sv
`timescale 1ns/1ps
`include "sat_settings.svh"

module flip_eval_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  assign_we_i,  // assignment load, between jobs only
    input  logic [`SAT_LAW-1:0]   assign_var_i,
    input  logic                  assign_val_i,
    input  logic                  start_i,      // one-cycle job start
    input  sat_pkg::clause_t      clause_i,     // unsatisfied clause
    input  logic                  occ_valid_i,  // occurrence stream
    input  sat_pkg::clause_rest_t occ_rest_i,
    input  logic                  occ_last_i,
    output logic                  done_o,       // result pulse
    output sat_pkg::flip_result_t result_o      // valid with done_o
);

    logic [`SAT_NUM_VARS-1:0]  values;
    logic                      buf_we;
    sat_pkg::buf_write_t       buf_write;
    logic                      count_valid;
    sat_pkg::count_msg_t       count_msg;
    logic                      rd_en;
    logic [`SAT_NSAT_BITS-1:0] rd_index;
    logic [`SAT_BREAK_W-1:0]   best_count;
    sat_pkg::literal_t         flip_lit;
    sat_pkg::clause_t          broken_clause;

    assignment_store u_assign (
        .clk(clk), .reset(reset),
        .load_we_i(assign_we_i), .load_var_i(assign_var_i), .load_val_i(assign_val_i),
        .commit_i(done_o), .commit_lit_i(flip_lit), // commit at the end of the done cycle
        .values_o(values)
    );

    break_counter u_count (
        .clk(clk), .reset(reset), .start_i(start_i),
        .occ_valid_i(occ_valid_i), .occ_rest_i(occ_rest_i), .occ_last_i(occ_last_i),
        .values_i(values), .buf_we_o(buf_we), .buf_write_o(buf_write),
        .count_valid_o(count_valid), .count_o(count_msg)
    );

    flip_selector u_select (
        .clk(clk), .reset(reset), .start_i(start_i),
        .count_valid_i(count_valid), .count_i(count_msg),
        .rd_en_o(rd_en), .rd_index_o(rd_index), .done_o(done_o),
        .best_index_o(), .best_count_o(best_count)
    );

    temporal_buffer_wrapper u_buf (
        .clk(clk), .reset(reset), .start_i(start_i), .clause_i(clause_i),
        .buf_we_i(buf_we), .buf_write_i(buf_write),
        .rd_en_i(rd_en), .rd_index_i(rd_index),
        .flip_lit_o(flip_lit), .broken_clause_o(broken_clause)
    );

    assign result_o.flip_lit      = flip_lit;
    assign result_o.break_count   = best_count;
    assign result_o.broken_valid  = (best_count != '0); // zero breaks, nothing stored
    assign result_o.broken_clause = broken_clause;

endmodule

// File: test/flip_eval_tb.sv
`timescale 1ns/1ps
`include "sat_settings.svh"

module flip_eval_tb;

    localparam int NUM_JOBS     = 40;
    localparam int RESET_CYCLES = 16;
    localparam int JOB_CYCLES   = 20; // start, at most 12 occurrences, result wait
    localparam int MAX_CYCLES   = RESET_CYCLES + `SAT_NUM_VARS + NUM_JOBS * JOB_CYCLES + 20;

    logic                  clk;
    logic                  reset;
    logic                  assign_we_i;
    logic [`SAT_LAW-1:0]   assign_var_i;
    logic                  assign_val_i;
    logic                  start_i;
    sat_pkg::clause_t      clause_i;
    logic                  occ_valid_i;
    sat_pkg::clause_rest_t occ_rest_i;
    logic                  occ_last_i;
    logic                  done_o;
    sat_pkg::flip_result_t result_o;

    logic [31:0]              lfsr_state;
    logic [`SAT_NUM_VARS-1:0] model_vals; // reference copy of the assignment
    sat_pkg::flip_result_t    exp_res;    // expected result of the current job
    logic                     job_end;    // last occurrence of the job on the inputs
    logic                     end_d1;
    logic                     end_d2;     // done_o due now
    int                       cycle_cnt;
    int                       done_cnt;

    flip_eval_top uut (.*);

    always #20 clk = ~clk; // 40 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic sat_pkg::literal_t random_literal();
        logic [31:0] r;
        r = rand_bits(`SAT_LAW + 1);
        return r[`SAT_LAW:0]; // neg in the top bit
    endfunction

    function automatic logic lit_true(input sat_pkg::literal_t l);
        return model_vals[l.var_addr] ^ l.neg; // negated literal is true on a false variable
    endfunction

    function automatic logic rest_all_false(input sat_pkg::clause_rest_t r);
        logic res;
        res = 1'b1;
        for (int k = 0; k < `SAT_NSAT-1; k++) begin
            if (lit_true(r.lits[k])) res = 1'b0;
        end
        return res;
    endfunction

    // mode 0 random, 1 forced break, 2 forced hold
    function automatic sat_pkg::clause_rest_t make_rest(input int mode);
        sat_pkg::clause_rest_t r;
        for (int k = 0; k < `SAT_NSAT-1; k++) begin
            r.lits[k] = random_literal();
            if (mode == 1) r.lits[k].neg = model_vals[r.lits[k].var_addr]; // literal false
        end
        if (mode == 2 && rest_all_false(r)) r.lits[0].neg = ~r.lits[0].neg; // one literal true
        return r;
    endfunction

    // kind 2 ties all flips, kind 3 lets the last flip win on its final occurrence
    task automatic run_job(input int kind);
        sat_pkg::clause_t      clause;
        sat_pkg::clause_rest_t rest;
        sat_pkg::clause_rest_t last_rest [`SAT_NSAT];
        int                    breaks [`SAT_NSAT];
        int                    n_occ;
        int                    mode;
        int                    tie_cnt;
        int                    best;
        for (int f = 0; f < `SAT_NSAT; f++) begin
            clause.lits[f] = random_literal();
        end
        tie_cnt = rand_bits(2) % 3; // breaks per flip in a tied job
        @(negedge clk);
        start_i  = 1'b1;
        clause_i = clause; // held until the next start
        for (int f = 0; f < `SAT_NSAT; f++) begin
            breaks[f]    = 0;
            last_rest[f] = '0;
            case (kind)
                2:       n_occ = 2;
                3:       n_occ = (f < `SAT_NSAT-1) ? 3 : 2 + rand_bits(1);
                default: n_occ = 1 + rand_bits(2); // 1 to 4 occurrences
            endcase
            for (int k = 0; k < n_occ; k++) begin
                case (kind)
                    2:       mode = (k < tie_cnt) ? 1 : 2;
                    3:       mode = (f < `SAT_NSAT-1 || k == n_occ-1) ? 1 : 2;
                    default: mode = 0;
                endcase
                rest = make_rest(mode);
                if (rest_all_false(rest)) begin
                    breaks[f]++;
                    last_rest[f] = rest; // latest break of this flip
                end
                @(negedge clk);
                start_i     = 1'b0;
                occ_valid_i = 1'b1;
                occ_rest_i  = rest;
                occ_last_i  = (k == n_occ-1);
                job_end     = (f == `SAT_NSAT-1) && (k == n_occ-1);
            end
        end
        best = 0;
        for (int f = 1; f < `SAT_NSAT; f++) begin
            if (breaks[f] < breaks[best]) best = f; // tie keeps the earlier flip
        end
        exp_res.flip_lit     = clause.lits[best];
        exp_res.break_count  = `SAT_BREAK_W'(breaks[best]);
        exp_res.broken_valid = (breaks[best] != 0);
        exp_res.broken_clause.lits[0].neg      = ~clause.lits[best].neg; // complement first
        exp_res.broken_clause.lits[0].var_addr = clause.lits[best].var_addr;
        for (int k = 1; k < `SAT_NSAT; k++) begin
            exp_res.broken_clause.lits[k] = last_rest[best].lits[k-1];
        end
        @(negedge clk);
        occ_valid_i = 1'b0;
        occ_last_i  = 1'b0;
        job_end     = 1'b0;
        while (!done_o) @(negedge clk);
        model_vals[exp_res.flip_lit.var_addr] = ~model_vals[exp_res.flip_lit.var_addr];
    endtask

    always @(posedge clk) begin
        if (reset) begin
            end_d1 <= 1'b0;
            end_d2 <= 1'b0;
        end else begin
            end_d1 <= job_end;
            end_d2 <= end_d1; // result two cycles after the last occurrence
        end
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) abort_run("timeout, the jobs did not finish in time");
    end

    always @(negedge clk) begin
        if (!reset && done_o) done_cnt++;
    end

    done_timing: assert property (@(posedge clk) disable iff (reset) done_o == end_d2)
        else abort_run($sformatf("ERROR t=%0t done_o dut=%0b exp=%0b",
                                 $time, $sampled(done_o), $sampled(end_d2)));

    count_check: assert property (@(posedge clk) disable iff (reset)
        done_o |-> result_o.break_count == exp_res.break_count)
        else abort_run($sformatf("ERROR t=%0t result_o.break_count dut=%0d exp=%0d",
                                 $time, $sampled(result_o.break_count), exp_res.break_count));

    flip_check: assert property (@(posedge clk) disable iff (reset)
        done_o |-> result_o.flip_lit == exp_res.flip_lit)
        else abort_run($sformatf("ERROR t=%0t result_o.flip_lit dut=%h exp=%h",
                                 $time, $sampled(result_o.flip_lit), exp_res.flip_lit));

    valid_check: assert property (@(posedge clk) disable iff (reset)
        done_o |-> result_o.broken_valid == exp_res.broken_valid)
        else abort_run($sformatf("ERROR t=%0t result_o.broken_valid dut=%0b exp=%0b",
                                 $time, $sampled(result_o.broken_valid), exp_res.broken_valid));

    clause_check: assert property (@(posedge clk) disable iff (reset)
        done_o && exp_res.broken_valid |-> result_o.broken_clause == exp_res.broken_clause)
        else abort_run($sformatf("ERROR t=%0t result_o.broken_clause dut=%h exp=%h",
                                 $time, $sampled(result_o.broken_clause), exp_res.broken_clause));

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        assign_we_i  = 1'b0;
        assign_var_i = '0;
        assign_val_i = 1'b0;
        start_i      = 1'b0;
        clause_i     = '0;
        occ_valid_i  = 1'b0;
        occ_rest_i   = '0;
        occ_last_i   = 1'b0;
        lfsr_state   = 32'hf5171eab;
        model_vals   = '0;
        exp_res      = '0;
        job_end      = 1'b0;
        cycle_cnt    = 0;
        done_cnt     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int v = 0; v < `SAT_NUM_VARS; v++) begin
            @(negedge clk);
            assign_we_i   = 1'b1;
            assign_var_i  = `SAT_LAW'(v);
            assign_val_i  = (rand_bits(1) != 0);
            model_vals[v] = assign_val_i;
        end
        @(negedge clk);
        assign_we_i = 1'b0;
        repeat (3) @(negedge clk); // idle, done_o must stay low
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j % 4);
        end
        repeat (4) @(negedge clk);
        if (done_cnt == NUM_JOBS) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run($sformatf("saw %0d done pulses for %0d jobs", done_cnt, NUM_JOBS));
        end
    end

endmodule

// File: sources.f
+incdir+src
src/sat_pkg.sv
src/assignment_store.sv
src/break_counter.sv
src/flip_selector.sv
src/temporal_buffer.sv
src/temporal_buffer_wrapper.sv
src/flip_eval_top.sv
test/flip_eval_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module flip_eval_tb

status=0
output=$(./obj_dir/Vflip_eval_tb 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1
